//--- flist.f
design/ldst_isa_pkg.sv
design/ldst_bus_pkg.sv
design/spr_register.sv
design/ldst_agu.sv
design/ldst_request_stage.sv
design/load_align.sv
design/ldst_exec_port.sv
bench/data_mem_model.sv
bench/tb_ldst_exec_port.sv

//--- Bender.yml
package:
  name: ldst_exec_port

sources:
  - files:
      - design/ldst_isa_pkg.sv
      - design/ldst_bus_pkg.sv
      - design/spr_register.sv
      - design/ldst_agu.sv
      - design/ldst_request_stage.sv
      - design/load_align.sv
      - design/ldst_exec_port.sv
  - target: test
    files:
      - bench/data_mem_model.sv
      - bench/tb_ldst_exec_port.sv

//--- bench/tb_ldst_exec_port.sv
// Testbench for the load/store execute port
// Issues loads, stores, push, pop and SPR writes, keeps a byte array
// and an SPR copy as reference and checks every completion in order

`timescale 1ns/10ps
`default_nettype none

module tb_ldst_exec_port
	import ldst_isa_pkg::*, ldst_bus_pkg::*;
();

	localparam logic [31:0] SPR_INIT = 32'h0000_1000;

	logic        iCLOCK;
	logic        inRESET;
	logic        issue_valid;
	ldst_issue_t issue;
	logic        spr_set_valid;
	logic [31:0] spr_set;
	logic        stall_en;
	logic        lock;
	logic        dataio_req;
	dataio_req_t dataio;
	logic        dataio_busy;
	logic        resp_valid;
	logic [31:0] resp_data;
	logic        done_valid;
	exec_done_t  done;
	logic [31:0] spr;

	// Reference state
	logic [7:0]       ref_mem [0:4095];
	logic [31:0]      exp_spr;
	exec_done_t       exp_q [$];
	// Expected rw, order and address of each bus request
	logic [34:0]      req_q [$];
	logic [TAG_W-1:0] next_tag;
	integer           seed;
	int               errors;
	int               test_errors;
	int               n_issued;
	int               n_done;
	int               tests_passed;
	int               tests_failed;
	string            test_name;

	always #4 iCLOCK = ~iCLOCK;

	ldst_exec_port #(
		.SPR_RESET_VALUE (SPR_INIT)
	) ldst_exec_port_inst (
		.iCLOCK        (iCLOCK),
		.inRESET       (inRESET),
		.issue_valid   (issue_valid),
		.issue         (issue),
		.lock          (lock),
		.spr_set_valid (spr_set_valid),
		.spr_set       (spr_set),
		.dataio_req    (dataio_req),
		.dataio        (dataio),
		.dataio_busy   (dataio_busy),
		.resp_valid    (resp_valid),
		.resp_data     (resp_data),
		.done_valid    (done_valid),
		.done          (done),
		.spr           (spr)
	);

	data_mem_model data_mem_model_inst (
		.iCLOCK      (iCLOCK),
		.inRESET     (inRESET),
		.stall_en    (stall_en),
		.dataio_req  (dataio_req),
		.dataio      (dataio),
		.dataio_busy (dataio_busy),
		.resp_valid  (resp_valid),
		.resp_data   (resp_data)
	);

	// Request held steady while memory is busy
	assert property (@(posedge iCLOCK) disable iff (!inRESET)
		dataio_req && dataio_busy |=> dataio_req && $stable(dataio))
	else begin
		$display("[ERROR] %s: request changed while memory was busy", test_name);
		errors++;
	end

	// No new request starts from a locked cycle
	assert property (@(posedge iCLOCK) disable iff (!inRESET) lock |=> !$rose(dataio_req))
	else begin
		$display("[ERROR] %s: an operation was taken while lock was high", test_name);
		errors++;
	end

	// Each request taken by memory against the expected access
	always @(posedge iCLOCK) begin
		if (inRESET && dataio_req && !dataio_busy) begin
			if (req_q.size() == 0) begin
				$display("[ERROR] %s: bus request with no operation outstanding", test_name);
				errors++;
			end else begin
				assert ({dataio.rw, dataio.order, dataio.addr} === req_q[0])
				else begin
					$display("[ERROR] %s: request expected %h actual %h", test_name,
						req_q[0], {dataio.rw, dataio.order, dataio.addr});
					errors++;
				end
				void'(req_q.pop_front());
			end
		end
	end

	// Completions checked in issue order against the reference queue
	always @(posedge iCLOCK) begin
		if (inRESET && done_valid) begin
			n_done++;
			if (exp_q.size() == 0) begin
				$display("[ERROR] %s: completion with no operation outstanding", test_name);
				errors++;
			end else begin
				assert (done === exp_q[0])
				else begin
					$display("[ERROR] %s: completion expected %h actual %h",
						test_name, exp_q[0], done);
					errors++;
				end
				void'(exp_q.pop_front());
			end
		end
	end

	function automatic logic [7:0] fill_byte(input logic [11:0] a);
		return a[7:0] ^ {a[11:8], a[11:8]};
	endfunction

	function automatic int byte_count(input ldst_cmd_e cmd);
		case (cmd)
			LD8, ST8:   return 1;
			LD16, ST16: return 2;
			default:    return 4;
		endcase
	endfunction

	task automatic check_value(input string what, input logic [31:0] exp,
			input logic [31:0] act);
		assert (exp === act)
		else begin
			$display("[ERROR] %s: %s expected %h actual %h", test_name, what, exp, act);
			errors++;
		end
	endtask

	// Issues one operation and updates the reference once it is accepted
	task automatic run_op(input ldst_cmd_e cmd, input logic [31:0] s0,
			input logic [31:0] s1, input logic set_en = 1'b0,
			input logic [31:0] set_val = 32'h0);
		exec_done_t  exp;
		logic [31:0] base;
		logic [11:0] a;
		int          k;
		issue_valid   = 1'b1;
		issue         = '{cmd: cmd, source0: s0, source1: s1,
			commit_tag: next_tag, dest_reg: ~next_tag};
		spr_set_valid = set_en;
		spr_set       = set_val;
		do begin
			@(posedge iCLOCK);
		end while (lock);
		@(negedge iCLOCK);
		issue_valid   = 1'b0;
		spr_set_valid = 1'b0;
		n_issued++;
		exp = '{commit_tag: next_tag, dest_reg: ~next_tag, writeback: 1'b0, data: 32'h0};
		case (cmd)
			PUSH:    base = exp_spr - 32'd4;
			POP:     base = exp_spr;
			default: base = s1;
		endcase
		for (k = 0; k < byte_count(cmd); k++) begin
			a = base[11:0] + k[11:0];
			if (cmd inside {ST8, ST16, ST32, PUSH}) begin
				ref_mem[a] = s0[8*k +: 8];
			end else if (cmd != SPR_WRITE) begin
				exp.data[8*k +: 8] = ref_mem[a];
			end
		end
		exp.writeback = cmd inside {LD8, LD16, LD32, POP};
		case (cmd)
			PUSH:      exp_spr = base;
			POP:       exp_spr = exp_spr + 32'd4;
			SPR_WRITE: exp_spr = s0;
			default:   ;
		endcase
		// Free path load wins over the execute path
		if (set_en) begin
			exp_spr = set_val;
		end
		if (cmd != SPR_WRITE) begin
			exp_q.push_back(exp);
			// One, two or four bytes map to byte, half and word order
			req_q.push_back({!exp.writeback, access_order_e'(byte_count(cmd) >> 1), base});
		end
		check_value("spr", exp_spr, spr);
		next_tag++;
	endtask

	task automatic drain();
		while (exp_q.size() != 0 || lock || dataio_req) begin
			@(negedge iCLOCK);
		end
	endtask

	task automatic start_test(input string name);
		test_name   = name;
		test_errors = errors;
	endtask

	task automatic finish_test();
		drain();
		if (errors == test_errors) begin
			tests_passed++;
			$display("test %s: passed", test_name);
		end else begin
			tests_failed++;
			$display("test %s: failed with %0d errors", test_name, errors - test_errors);
		end
	endtask

	// Hang guard at 200 cycles per issued operation
	initial begin
		int cycles;
		cycles = 0;
		while (cycles <= 200 * (n_issued + 1)) begin
			@(posedge iCLOCK);
			cycles++;
		end
		$display("Watchdog: no progress after %0d cycles, the port appears hung", cycles);
		$display("RESULT: FAIL");
		$finish;
	end

	initial begin
		logic [31:0] r;
		logic [31:0] a;
		ldst_cmd_e   c;
		int          k;
		iCLOCK        = 1'b0;
		inRESET       = 1'b0;
		issue_valid   = 1'b0;
		issue         = '0;
		spr_set_valid = 1'b0;
		spr_set       = 32'h0;
		stall_en      = 1'b0;
		seed          = 32'h8d94;
		errors        = 0;
		n_issued      = 0;
		n_done        = 0;
		tests_passed  = 0;
		tests_failed  = 0;
		exp_spr       = SPR_INIT;
		next_tag      = '0;
		for (k = 0; k < 4096; k++) begin
			ref_mem[k] = fill_byte(k[11:0]);
		end

		start_test("reset");
		repeat (4) @(negedge iCLOCK);
		check_value("lock/req/done", 32'd0, {29'd0, lock, dataio_req, done_valid});
		check_value("spr", SPR_INIT, spr);
		inRESET = 1'b1;
		finish_test();

		start_test("store widths");
		run_op(ST32, 32'h1122_3344, 32'h100);
		run_op(ST8, 32'h0000_00aa, 32'h101);
		run_op(ST16, 32'h0000_beef, 32'h102);
		run_op(LD32, 32'h0, 32'h100);
		for (k = 0; k < 4; k++) begin
			run_op(ST8, 32'h50 + k, 32'h104 + k);
		end
		run_op(ST16, 32'h0000_c0de, 32'h108);
		run_op(ST16, 32'h0000_f00d, 32'h10a);
		run_op(LD32, 32'h0, 32'h104);
		run_op(LD32, 32'h0, 32'h108);
		finish_test();

		start_test("narrow loads");
		for (k = 0; k < 8; k++) begin
			run_op(LD8, 32'h0, 32'h100 + k);
		end
		for (k = 0; k < 3; k++) begin
			run_op(LD16, 32'h0, 32'h104 + k);
		end
		finish_test();

		start_test("push pop");
		run_op(PUSH, 32'hcafe_0001, 32'h0);
		run_op(PUSH, 32'hcafe_0002, 32'h0);
		run_op(POP, 32'h0, 32'h0);
		run_op(POP, 32'h0, 32'h0);
		drain();
		run_op(PUSH, 32'h1234_5678, 32'h0, 1'b1, 32'h0000_0800);
		run_op(POP, 32'h0, 32'h0);
		drain();
		run_op(SPR_WRITE, SPR_INIT, 32'h0);
		finish_test();

		// Command codes 0 to 7 cover loads, stores, push and pop
		start_test("random stalls");
		stall_en = 1'b1;
		for (k = 0; k < 60; k++) begin
			r = $random(seed);
			c = ldst_cmd_e'({2'b00, r[2:0]});
			a = (32'h200 | {24'h0, r[15:8]}) & ~(byte_count(c) - 1);
			run_op(c, $random(seed), a);
		end
		drain();
		stall_en = 1'b0;
		finish_test();

		start_test("spr write");
		run_op(SPR_WRITE, 32'h0000_0f00, 32'h0);
		check_value("dataio_req", 32'd0, {31'd0, dataio_req});
		repeat (3) @(negedge iCLOCK);
		finish_test();

		$display("tests passed %0d failed %0d, operations %0d, completions %0d",
			tests_passed, tests_failed, n_issued, n_done);
		if (tests_failed == 0 && errors == 0) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- bench/data_mem_model.sv
// Data memory model
// Byte-addressed memory on the data port, 4 KB wrapping, with a
// random busy level and response delay when stalls are enabled

`timescale 1ns/10ps
`default_nettype none

module data_mem_model
	import ldst_isa_pkg::*, ldst_bus_pkg::*;
(
	input  wire          iCLOCK,
	input  wire          inRESET,
	input  wire          stall_en,
	input  wire          dataio_req,
	input  dataio_req_t  dataio,
	output logic         dataio_busy,
	output logic         resp_valid,
	output logic  [31:0] resp_data
);

	logic [7:0]  mem [0:4095];
	logic        took;
	dataio_req_t took_op;
	logic        waiting;
	logic [1:0]  wait_cnt;
	logic [11:0] load_addr;
	logic [31:0] rnd;
	integer      seed;

	function automatic logic [31:0] read_word(input logic [11:0] a);
		return {mem[{a[11:2], 2'd3}], mem[{a[11:2], 2'd2}],
			mem[{a[11:2], 2'd1}], mem[{a[11:2], 2'd0}]};
	endfunction

	// Fill pattern covers all 12 address bits
	initial begin
		seed = 32'h8d94;
		for (int a = 0; a < 4096; a++) begin
			mem[a] = a[7:0] ^ {a[11:8], a[11:8]};
		end
	end

	// Request taken on the rising edge
	always @(posedge iCLOCK) begin
		took    <= dataio_req && !dataio_busy && inRESET;
		took_op <= dataio;
	end

	// Outputs change on the falling edge
	always @(negedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			dataio_busy <= 1'b0;
			resp_valid  <= 1'b0;
			resp_data   <= 32'h0;
			waiting     <= 1'b0;
			wait_cnt    <= 2'd0;
			load_addr   <= 12'h0;
		end else begin
			rnd = $random(seed);
			resp_valid  <= 1'b0;
			dataio_busy <= stall_en && rnd[0];
			if (took && took_op.rw) begin
				for (int i = 0; i < 4; i++) begin
					if (took_op.order == WORD ||
					    (took_op.order == HALF && i[1] == took_op.addr[1]) ||
					    i[1:0] == took_op.addr[1:0]) begin
						mem[{took_op.addr[11:2], i[1:0]}] <= took_op.data[8*i +: 8];
					end
				end
			end
			if (took && !took_op.rw) begin
				waiting   <= 1'b1;
				wait_cnt  <= stall_en ? rnd[5:4] : 2'd0;
				load_addr <= took_op.addr[11:0];
			end else if (waiting) begin
				if (wait_cnt == 2'd0) begin
					resp_valid <= 1'b1;
					resp_data  <= read_word(load_addr);
					waiting    <= 1'b0;
				end else begin
					wait_cnt <= wait_cnt - 2'd1;
				end
			end
		end
	end

endmodule

`default_nettype wire

//--- design/ldst_exec_port.sv
// Load/store execute port
// Accepts one memory operation per cycle from the scheduler, keeps
// the stack pointer, drives the 32-bit data port with one request at
// a time and returns completions with load data

`timescale 1ns/10ps
`default_nettype none

module ldst_exec_port
	import ldst_isa_pkg::*, ldst_bus_pkg::*;
#(
	parameter logic [31:0] SPR_RESET_VALUE = 32'h0000_0000
) (
	input  wire          iCLOCK,
	input  wire          inRESET,
	// Scheduler issue
	input  wire          issue_valid,
	input  ldst_issue_t  issue,
	output logic         lock,
	// Free path SPR load
	input  wire          spr_set_valid,
	input  wire   [31:0] spr_set,
	// Data port
	output logic         dataio_req,
	output dataio_req_t  dataio,
	input  wire          dataio_busy,
	input  wire          resp_valid,
	input  wire   [31:0] resp_data,
	// Completion
	output logic         done_valid,
	output exec_done_t   done,
	output logic  [31:0] spr
);

	dataio_req_t       bus_op;
	load_lane_t        lane;
	load_lane_t        held_lane;
	logic              is_bus;
	logic              spr_update;
	logic       [31:0] spr_next;
	logic              accept;
	logic [TAG_W-1:0]  done_tag;
	logic [REG_W-1:0]  done_reg;
	logic              done_wb;
	logic       [31:0] load_value;

	spr_register #(
		.SPR_RESET_VALUE (SPR_RESET_VALUE)
	) spr_register_inst (
		.iCLOCK     (iCLOCK),
		.inRESET    (inRESET),
		.free_valid (spr_set_valid),
		.free_value (spr_set),
		.exec_valid (accept && spr_update),
		.exec_value (spr_next),
		.value      (spr)
	);

	ldst_agu ldst_agu_inst (
		.issue      (issue),
		.spr_value  (spr),
		.bus_op     (bus_op),
		.lane       (lane),
		.is_bus     (is_bus),
		.spr_update (spr_update),
		.spr_next   (spr_next)
	);

	ldst_request_stage ldst_request_stage_inst (
		.iCLOCK      (iCLOCK),
		.inRESET     (inRESET),
		.issue_valid (issue_valid),
		.issue       (issue),
		.bus_op      (bus_op),
		.lane        (lane),
		.is_bus      (is_bus),
		.dataio_busy (dataio_busy),
		.resp_valid  (resp_valid),
		.accept      (accept),
		.lock        (lock),
		.dataio_req  (dataio_req),
		.dataio      (dataio),
		.held_lane   (held_lane),
		.done_valid  (done_valid),
		.done_tag    (done_tag),
		.done_reg    (done_reg),
		.done_wb     (done_wb)
	);

	load_align load_align_inst (
		.lane      (held_lane),
		.resp_data (resp_data),
		.value     (load_value)
	);

	// Store completions carry no data
	assign done = '{
		commit_tag: done_tag,
		dest_reg:   done_reg,
		writeback:  done_wb,
		data:       done_wb ? load_value : 32'h0
	};

endmodule

`default_nettype wire

//--- design/load_align.sv
// Load data alignment
// Moves the addressed bytes of the response down to bit 0, keeps
// the bytes of the access width and zero-extends the rest

`timescale 1ns/10ps
`default_nettype none

module load_align
	import ldst_bus_pkg::*;
(
	input  load_lane_t   lane,
	input  wire   [31:0] resp_data,
	output logic  [31:0] value
);

	logic [31:0] shifted;
	logic [31:0] byte_mask;

	// Eight bits per byte of offset
	assign shifted = resp_data >> {lane.shift, 3'b000};

	// Expand the byte mask to bit granularity
	assign byte_mask = {
		{8{lane.mask[3]}},
		{8{lane.mask[2]}},
		{8{lane.mask[1]}},
		{8{lane.mask[0]}}
	};

	assign value = shifted & byte_mask;

endmodule

`default_nettype wire

//--- design/ldst_request_stage.sv
// Load/store request stage
// Registers one bus request per accepted operation, holds it while
// memory is busy, waits for the response of a load and reports one
// completion per bus operation; also drives the issue lock

`timescale 1ns/10ps
`default_nettype none

module ldst_request_stage
	import ldst_isa_pkg::*, ldst_bus_pkg::*;
(
	input  wire               iCLOCK,
	input  wire               inRESET,
	input  wire               issue_valid,
	input  ldst_issue_t       issue,
	input  dataio_req_t       bus_op,
	input  load_lane_t        lane,
	input  wire               is_bus,
	input  wire               dataio_busy,
	input  wire               resp_valid,
	output logic              accept,
	output logic              lock,
	output logic              dataio_req,
	output dataio_req_t       dataio,
	output load_lane_t        held_lane,
	output logic              done_valid,
	output logic [TAG_W-1:0]  done_tag,
	output logic [REG_W-1:0]  done_reg,
	output logic              done_wb
);

	typedef enum logic {
		ST_IDLE,
		ST_LOAD_WAIT
	} ldst_state_e;

	ldst_state_e state;
	logic        taken;
	logic        load_taken;
	logic        load_done;

	// Memory takes the request this cycle
	assign taken      = dataio_req && !dataio_busy;
	assign load_taken = taken && !dataio.rw;
	assign load_done  = (state == ST_LOAD_WAIT) && resp_valid;

	// Hold issue while the request is stuck on busy, or a load
	// is outstanding; release in the cycle its response arrives
	assign lock   = (dataio_req && (dataio_busy || !dataio.rw)) ||
	                ((state == ST_LOAD_WAIT) && !resp_valid);
	assign accept = issue_valid && !lock;

	// Request valid
	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			dataio_req <= 1'b0;
		end else if (accept && is_bus) begin
			dataio_req <= 1'b1;
		end else if (taken) begin
			dataio_req <= 1'b0;
		end
	end

	// Request payload, tag and destination
	always_ff @(posedge iCLOCK) begin
		if (accept && is_bus) begin
			dataio    <= bus_op;
			held_lane <= lane;
			done_tag  <= issue.commit_tag;
			done_reg  <= issue.dest_reg;
		end
	end

	// Load-wait FSM
	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			state <= ST_IDLE;
		end else begin
			case (state)
				ST_IDLE: begin
					if (load_taken) begin
						state <= ST_LOAD_WAIT;
					end
				end
				ST_LOAD_WAIT: begin
					if (resp_valid) begin
						state <= ST_IDLE;
					end
				end
				default: begin
					state <= ST_IDLE;
				end
			endcase
		end
	end

	// Stores finish when taken, loads on their response
	assign done_valid = (taken && dataio.rw) || load_done;
	assign done_wb    = (state == ST_LOAD_WAIT);

endmodule

`default_nettype wire

//--- design/ldst_agu.sv
// Load/store address generation
// Decodes one issued command into the data port request, the lane
// used to pick bytes out of the load response, and the next SPR
// value for push, pop and system writes

`timescale 1ns/10ps
`default_nettype none

module ldst_agu
	import ldst_isa_pkg::*, ldst_bus_pkg::*;
(
	input  ldst_issue_t  issue,
	input  wire   [31:0] spr_value,
	output dataio_req_t  bus_op,
	output load_lane_t   lane,
	output logic         is_bus,
	output logic         spr_update,
	output logic  [31:0] spr_next
);

	logic [31:0] spr_dec;
	logic [31:0] spr_inc;

	assign spr_dec = spr_value - 32'd4;
	assign spr_inc = spr_value + 32'd4;

	always_comb begin
		// Defaults describe a plain word read at source1
		bus_op.rw    = 1'b0;
		bus_op.order = WORD;
		bus_op.addr  = issue.source1;
		bus_op.data  = issue.source0;
		lane.shift   = issue.source1[1:0];
		lane.mask    = MASK_WORD;
		is_bus       = 1'b1;
		spr_update   = 1'b0;
		spr_next     = spr_value;

		case (issue.cmd)
			LD8: begin
				bus_op.order = BYTE;
				lane.mask    = MASK_BYTE;
			end
			LD16: begin
				bus_op.order = HALF;
				lane.mask    = MASK_HALF;
			end
			LD32: begin
				bus_op.order = WORD;
			end
			ST8: begin
				bus_op.rw    = 1'b1;
				bus_op.order = BYTE;
				// Same byte on every lane so memory picks it by address
				bus_op.data  = {4{issue.source0[7:0]}};
			end
			ST16: begin
				bus_op.rw    = 1'b1;
				bus_op.order = HALF;
				bus_op.data  = {2{issue.source0[15:0]}};
			end
			ST32: begin
				bus_op.rw    = 1'b1;
			end
			PUSH: begin
				// Pre-decrement, then word store
				bus_op.rw    = 1'b1;
				bus_op.addr  = spr_dec;
				spr_update   = 1'b1;
				spr_next     = spr_dec;
			end
			POP: begin
				// Word load at SPR, then post-increment
				bus_op.addr  = spr_value;
				lane.shift   = spr_value[1:0];
				spr_update   = 1'b1;
				spr_next     = spr_inc;
			end
			SPR_WRITE: begin
				is_bus       = 1'b0;
				spr_update   = 1'b1;
				spr_next     = issue.source0;
			end
			default: begin
				is_bus       = 1'b0;
			end
		endcase
	end

endmodule

`default_nettype wire

//--- design/spr_register.sv
// Stack pointer register
// Holds the SPR; a write from the free path takes priority over
// an update coming from the execute path in the same cycle

`timescale 1ns/10ps
`default_nettype none

module spr_register #(
	parameter logic [31:0] SPR_RESET_VALUE = 32'h0000_0000
) (
	input  wire         iCLOCK,
	input  wire         inRESET,
	input  wire         free_valid,
	input  wire  [31:0] free_value,
	input  wire         exec_valid,
	input  wire  [31:0] exec_value,
	output logic [31:0] value
);

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			value <= SPR_RESET_VALUE;
		end else if (free_valid) begin
			// Out-of-band load wins
			value <= free_value;
		end else if (exec_valid) begin
			value <= exec_value;
		end
	end

endmodule

`default_nettype wire

//--- design/ldst_bus_pkg.sv
// Load/store execute port, data port definitions
// Request word driven towards memory and the byte lane
// selection kept for aligning the load response

`default_nettype none

package ldst_bus_pkg;

	import ldst_isa_pkg::*;

	// Request on the 32-bit data port
	typedef struct packed {
		logic           rw;      // 1 = write
		access_order_e  order;
		logic [31:0]    addr;
		// Store data, already on its byte lane
		logic [31:0]    data;
	} dataio_req_t;

	// Byte selection for a pending load
	typedef struct packed {
		logic [1:0]     shift;   // Byte offset within the word
		logic [3:0]     mask;    // One bit per byte kept
	} load_lane_t;

	// Lane masks per access width
	localparam logic [3:0] MASK_BYTE = 4'b0001;
	localparam logic [3:0] MASK_HALF = 4'b0011;
	localparam logic [3:0] MASK_WORD = 4'b1111;

endpackage

`default_nettype wire

//--- design/ldst_isa_pkg.sv
// Load/store execute port, issue side definitions
// Command encoding, access widths and the records exchanged with
// the scheduler on issue and on completion

`default_nettype none

package ldst_isa_pkg;

	// Commit tag and physical register name widths
	localparam int TAG_W = 6;
	localparam int REG_W = 6;

	// Memory commands handled by this port
	typedef enum logic [4:0] {
		LD8       = 5'd0,
		LD16      = 5'd1,
		LD32      = 5'd2,
		ST8       = 5'd3,
		ST16      = 5'd4,
		ST32      = 5'd5,
		PUSH      = 5'd6,
		POP       = 5'd7,
		SPR_WRITE = 5'd8
	} ldst_cmd_e;

	// Access width on the data port
	typedef enum logic [1:0] {
		BYTE = 2'b00,
		HALF = 2'b01,
		WORD = 2'b10
	} access_order_e;

	// One issued operation from the scheduler
	typedef struct packed {
		ldst_cmd_e          cmd;
		logic [31:0]        source0;     // Store data or new SPR value
		logic [31:0]        source1;     // Address
		logic [TAG_W-1:0]   commit_tag;
		logic [REG_W-1:0]   dest_reg;
	} ldst_issue_t;

	// Completion record back to the scheduler
	typedef struct packed {
		logic [TAG_W-1:0]   commit_tag;
		logic [REG_W-1:0]   dest_reg;
		logic               writeback;   // Loads and pops
		logic [31:0]        data;
	} exec_done_t;

endpackage

`default_nettype wire
